// ==== chess_pkg.sv ====
package chess_pkg;

    // square address, row 0 is black's back rank, col 0 is the a-file
    typedef struct packed {
        logic [2:0] row;
        logic [2:0] col;
    } sq_t;

    typedef enum logic {
        WHITE = 1'b0,
        BLACK = 1'b1
    } color_e;

    typedef enum logic [2:0] {
        NONE   = 3'd0,
        PAWN   = 3'd1,
        KNIGHT = 3'd2,
        BISHOP = 3'd3,
        ROOK   = 3'd4,
        QUEEN  = 3'd5,
        KING   = 3'd6
    } kind_e;

    typedef struct packed {
        color_e color;
        kind_e  kind;
    } piece_t;

    typedef piece_t [63:0] board_t; // index is {row, col}

    typedef struct packed {
        logic   en;
        sq_t    addr;
        piece_t piece;
    } board_wr_t;

    typedef enum logic [2:0] {
        CMD_LEFT,
        CMD_RIGHT,
        CMD_UP,
        CMD_DOWN,
        CMD_SELECT
    } cmd_e;

    typedef struct packed {
        logic valid;
        cmd_e op;
    } cmd_pulse_t;

    typedef enum logic [1:0] {
        PIECE_SEL,
        PIECE_MOVE,
        WRITE_NEW,
        ERASE_OLD
    } fsm_state_e;

    localparam piece_t EMPTY_PIECE = '{color: WHITE, kind: NONE};

    ////////////////////////////////////////////////////////////
    // opening position

    function automatic kind_e back_rank_kind(input int col);
        case (col)
            0, 7:    return ROOK;
            1, 6:    return KNIGHT;
            2, 5:    return BISHOP;
            3:       return QUEEN;
            default: return KING;
        endcase
    endfunction

    function automatic board_t opening_board();
        board_t b;
        b = '0; // all empty
        for (int c = 0; c < 8; c++) begin
            b[c]      = '{color: BLACK, kind: back_rank_kind(c)};
            b[8 + c]  = '{color: BLACK, kind: PAWN};
            b[48 + c] = '{color: WHITE, kind: PAWN};
            b[56 + c] = '{color: WHITE, kind: back_rank_kind(c)};
        end
        return b;
    endfunction

    localparam board_t OPENING_BOARD = opening_board();

endpackage

// ==== button_port.sv ====
`timescale 1ns/1ps

module button_port (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  cmd_req,
    input  chess_pkg::cmd_e       cmd,
    input  logic                  busy,
    output logic                  cmd_ack,
    output chess_pkg::cmd_pulse_t cmd_pulse
);

    typedef enum logic {
        PORT_IDLE,
        PORT_ACK
    } port_state_e;

    port_state_e state;

    // ack is the state itself
    assign cmd_ack = (state == PORT_ACK);

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            state     <= PORT_IDLE;
            cmd_pulse <= '0;
        end else begin
            cmd_pulse.valid <= 1'b0; // single cycle pulse
            case (state)
                PORT_IDLE: begin
                    if (cmd_req && !busy) begin // hold off while a move is written
                        state           <= PORT_ACK;
                        cmd_pulse.valid <= 1'b1;
                        cmd_pulse.op    <= cmd;
                    end
                end
                PORT_ACK: begin
                    if (!cmd_req)
                        state <= PORT_IDLE; // req dropped, release ack
                end
            endcase
        end
    end

    // ack only comes up in answer to a pending request
    a_ack_needs_req : assert property (
        @(posedge CLK) disable iff (RESET)
        $rose(cmd_ack) |-> $past(cmd_req)
    );

endmodule

// ==== cursor_ctrl.sv ====
`timescale 1ns/1ps

module cursor_ctrl #(
    parameter chess_pkg::sq_t CURSOR_START = '{row: 3'd6, col: 3'd4}
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  chess_pkg::cmd_pulse_t cmd_pulse,
    output chess_pkg::sq_t        cursor
);

    import chess_pkg::*;

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            cursor <= CURSOR_START;
        end else if (cmd_pulse.valid) begin
            case (cmd_pulse.op)
                CMD_LEFT:  if (cursor.col != 3'd0) cursor.col <= cursor.col - 3'd1;
                CMD_RIGHT: if (cursor.col != 3'd7) cursor.col <= cursor.col + 3'd1;
                CMD_UP:    if (cursor.row != 3'd0) cursor.row <= cursor.row - 3'd1;
                CMD_DOWN:  if (cursor.row != 3'd7) cursor.row <= cursor.row + 3'd1;
                default: ; // select does not move the cursor
            endcase
        end
    end

    // any cursor change traces back to a step pulse one cycle earlier
    a_cursor_needs_step : assert property (
        @(posedge CLK) disable iff (RESET)
        $changed(cursor) |-> $past(cmd_pulse.valid) && ($past(cmd_pulse.op) != CMD_SELECT)
    );

endmodule

// ==== move_checker.sv ====
`timescale 1ns/1ps

module move_checker (
    input  chess_pkg::board_t board,
    input  chess_pkg::sq_t    selected,
    input  chess_pkg::sq_t    cursor,
    input  chess_pkg::color_e side,
    output logic              legal
);

    import chess_pkg::*;

    piece_t            sel_piece;
    piece_t            dst_piece;
    piece_t            mid_piece;
    sq_t               mid_sq;
    logic signed [3:0] h;
    logic signed [3:0] v;
    logic signed [3:0] fwd;
    logic        [2:0] ah;
    logic        [2:0] av;
    logic        [2:0] home_row;
    logic              dst_empty;
    logic              dst_enemy;
    logic              diag_ok;
    logic              line_ok;
    logic              pawn_ok;

    assign sel_piece = board[selected];
    assign dst_piece = board[cursor];

    ////////////////////////////////////////////////////////////
    // deltas, positive h is rightward, positive v is downward

    assign h  = $signed({1'b0, cursor.col}) - $signed({1'b0, selected.col});
    assign v  = $signed({1'b0, cursor.row}) - $signed({1'b0, selected.row});
    assign ah = h[3] ? 3'(-h) : h[2:0];
    assign av = v[3] ? 3'(-v) : v[2:0];

    assign dst_empty = (dst_piece.kind == NONE);
    assign dst_enemy = !dst_empty && (dst_piece.color != side);

    assign diag_ok = (ah == av) && (ah != 3'd0);
    assign line_ok = (h == 4'sd0) != (v == 4'sd0); // exactly one axis moves

    ////////////////////////////////////////////////////////////
    // pawn, forward depends on colour

    assign fwd      = (side == WHITE) ? -4'sd1 : 4'sd1;
    assign home_row = (side == WHITE) ? 3'd6 : 3'd1;

    // square passed over by a double step
    assign mid_sq.row = (side == WHITE) ? selected.row - 3'd1 : selected.row + 3'd1;
    assign mid_sq.col = selected.col;
    assign mid_piece  = board[mid_sq];

    assign pawn_ok =
        (h == 4'sd0 && v == fwd && dst_empty)
        || (h == 4'sd0 && v == 4'sd2 * fwd && selected.row == home_row
            && dst_empty && mid_piece.kind == NONE)
        || (ah == 3'd1 && v == fwd && dst_enemy); // diagonal capture

    always_comb begin
        case (sel_piece.kind)
            PAWN:    legal = pawn_ok;
            KNIGHT:  legal = (ah == 3'd2 && av == 3'd1) || (ah == 3'd1 && av == 3'd2);
            BISHOP:  legal = diag_ok;
            ROOK:    legal = line_ok;
            QUEEN:   legal = diag_ok || line_ok;
            KING:    legal = (ah <= 3'd1) && (av <= 3'd1) && ((ah | av) != 3'd0);
            default: legal = 1'b0; // nothing held
        endcase
    end

endmodule

// ==== board_store.sv ====
`timescale 1ns/1ps

module board_store (
    input  logic                 CLK,
    input  logic                 RESET,
    input  chess_pkg::board_wr_t board_wr,
    input  chess_pkg::sq_t       peek_sq,
    output chess_pkg::board_t    board,
    output chess_pkg::piece_t    peek_piece
);

    import chess_pkg::*;

    // one square per enabled cycle
    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            board <= OPENING_BOARD;
        end else if (board_wr.en) begin
            board[board_wr.addr] <= board_wr.piece;
        end
    end

    assign peek_piece = board[peek_sq]; // straight off the register

    // address comes from the move FSM, must be resolved whenever it writes
    a_wr_addr_known : assert property (
        @(posedge CLK) disable iff (RESET)
        board_wr.en |-> !$isunknown(board_wr.addr)
    );

endmodule

// ==== turn_fsm.sv ====
`timescale 1ns/1ps

module turn_fsm (
    input  logic                  CLK,
    input  logic                  RESET,
    input  chess_pkg::cmd_pulse_t cmd_pulse,
    input  chess_pkg::sq_t        cursor,
    input  chess_pkg::board_t     board,
    input  logic                  legal,
    output logic                  busy,
    output chess_pkg::board_wr_t  board_wr,
    output chess_pkg::sq_t        selected,
    output chess_pkg::color_e     side,
    output logic                  piece_held
);

    import chess_pkg::*;

    fsm_state_e state;
    sq_t        dest;       // latched destination
    piece_t     cur_piece;
    piece_t     held_piece;
    logic       select_hit;
    logic       cur_own;
    logic       move_ok;

    assign cur_piece  = board[cursor];
    assign held_piece = board[selected]; // origin is still intact during WRITE_NEW
    assign cur_own    = (cur_piece.kind != NONE) && (cur_piece.color == side);
    assign select_hit = cmd_pulse.valid && (cmd_pulse.op == CMD_SELECT);
    assign move_ok    = select_hit && !cur_own && legal;

    assign busy       = (state == WRITE_NEW) || (state == ERASE_OLD);
    assign piece_held = (state == PIECE_MOVE);

    ////////////////////////////////////////////////////////////
    // state, selection and side to move

    always_ff @(posedge CLK or posedge RESET) begin
        if (RESET) begin
            state    <= PIECE_SEL;
            side     <= WHITE;
            selected <= '0;
        end else begin
            case (state)
                PIECE_SEL: begin
                    if (select_hit && cur_own) begin // pick up own piece
                        selected <= cursor;
                        state    <= PIECE_MOVE;
                    end
                end
                PIECE_MOVE: begin
                    if (select_hit && cur_own)
                        selected <= cursor; // reselect
                    else if (move_ok)
                        state <= WRITE_NEW;
                end
                WRITE_NEW: state <= ERASE_OLD;
                ERASE_OLD: begin
                    side  <= (side == WHITE) ? BLACK : WHITE; // hand over the turn
                    state <= PIECE_SEL;
                end
                default: state <= PIECE_SEL;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == PIECE_MOVE && move_ok)
            dest <= cursor;
    end

    ////////////////////////////////////////////////////////////
    // board write sequencing

    always_comb begin
        board_wr = '{en: 1'b0, addr: dest, piece: held_piece};
        case (state)
            WRITE_NEW: board_wr.en = 1'b1; // piece lands at destination
            ERASE_OLD: board_wr = '{en: 1'b1, addr: selected, piece: EMPTY_PIECE};
            default: ;
        endcase
    end

    // the two writes of a move are never split
    a_write_then_erase : assert property (
        @(posedge CLK) disable iff (RESET)
        (state == WRITE_NEW) |=> (state == ERASE_OLD)
    );

endmodule

// ==== chess_top.sv ====
`timescale 1ns/1ps

module chess_top #(
    parameter chess_pkg::sq_t CURSOR_START = '{row: 3'd6, col: 3'd4}
) (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              cmd_req,
    input  chess_pkg::cmd_e   cmd,
    input  chess_pkg::sq_t    peek_sq,
    output logic              cmd_ack,
    output chess_pkg::piece_t peek_piece,
    output chess_pkg::sq_t    cursor,
    output chess_pkg::sq_t    selected,
    output logic              piece_held,
    output chess_pkg::color_e side
);

    import chess_pkg::*;

    cmd_pulse_t cmd_pulse;
    board_wr_t  board_wr;
    board_t     board;
    logic       busy;
    logic       legal;

    button_port i_button_port (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .busy      (busy),
        .cmd_ack   (cmd_ack),
        .cmd_pulse (cmd_pulse)
    );

    cursor_ctrl #(
        .CURSOR_START (CURSOR_START)
    ) i_cursor_ctrl (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_pulse (cmd_pulse),
        .cursor    (cursor)
    );

    move_checker i_move_checker (
        .board    (board),
        .selected (selected),
        .cursor   (cursor),
        .side     (side),
        .legal    (legal)
    );

    board_store i_board_store (
        .CLK        (CLK),
        .RESET      (RESET),
        .board_wr   (board_wr),
        .peek_sq    (peek_sq),
        .board      (board),
        .peek_piece (peek_piece)
    );

    turn_fsm i_turn_fsm (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_pulse  (cmd_pulse),
        .cursor     (cursor),
        .board      (board),
        .legal      (legal),
        .busy       (busy),
        .board_wr   (board_wr),
        .selected   (selected),
        .side       (side),
        .piece_held (piece_held)
    );

endmodule

// ==== tb_chess_checks.svh ====
`ifndef TB_CHESS_CHECKS_SVH
`define TB_CHESS_CHECKS_SVH

localparam int ACK_TIMEOUT  = 32; // cycles per handshake phase
localparam int IDLE_TIMEOUT = 20; // cycles for a move's write sequence

int checks_run   = 0;
int errors_seen  = 0;
int errors_start = 0; // error count when the current test began

////////////////////////////////////////////////////////////
// typed compares

task automatic check_sq(input string name, input sq_t got, input sq_t exp);
    checks_run++;
    if (got !== exp) begin
        errors_seen++;
        $display("FAIL t=%0t %s got row %0d col %0d, expected row %0d col %0d",
                 $time, name, got.row, got.col, exp.row, exp.col);
    end
endtask

task automatic check_piece(input string name, input piece_t got, input piece_t exp);
    color_e gc;
    kind_e  gk;
    color_e ec;
    kind_e  ek;
    gc = got.color;
    gk = got.kind;
    ec = exp.color;
    ek = exp.kind;
    checks_run++;
    if (got !== exp) begin
        errors_seen++;
        $display("FAIL t=%0t %s got %s %s, expected %s %s",
                 $time, name, gc.name(), gk.name(), ec.name(), ek.name());
    end
endtask

task automatic check_color(input string name, input color_e got, input color_e exp);
    checks_run++;
    if (got !== exp) begin
        errors_seen++;
        $display("FAIL t=%0t %s got %s, expected %s", $time, name, got.name(), exp.name());
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks_run++;
    if (got !== exp) begin
        errors_seen++;
        $display("FAIL t=%0t %s got %b, expected %b", $time, name, got, exp);
    end
endtask

////////////////////////////////////////////////////////////
// command port and idle wait

// one full four-phase transaction, returns once ack has dropped
task automatic send_cmd(input cmd_e op);
    int n;
    @(negedge CLK);
    cmd     = op;
    cmd_req = 1'b1;
    n       = 0;
    while (!cmd_ack && n < ACK_TIMEOUT) begin
        @(negedge CLK);
        n++;
    end
    if (!cmd_ack) begin
        abort_run("cmd_ack never rose after cmd_req was raised");
    end else begin
        cmd_req = 1'b0; // release, port drops ack next edge
        n       = 0;
        while (cmd_ack && n < ACK_TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (cmd_ack)
            abort_run("cmd_ack stayed high after cmd_req was dropped");
    end
endtask

// board writes in flight while busy
task automatic wait_idle();
    int n;
    n = 0;
    while (i_chess_top.busy && n < IDLE_TIMEOUT) begin
        @(negedge CLK);
        n++;
    end
    if (i_chess_top.busy)
        abort_run("move write sequence never finished");
endtask

task automatic start_test();
    errors_start = errors_seen;
endtask

task automatic finish_test(input string name);
    if (errors_seen == errors_start)
        $display("test %s: passed", name);
    else
        $display("test %s: failed with %0d errors", name, errors_seen - errors_start);
endtask

`endif

// ==== tb_chess.sv ====
`timescale 1ns/1ps

module tb_chess;

    import chess_pkg::*;

    localparam piece_t NO_PIECE = '{color: WHITE, kind: NONE};

    logic   CLK;
    logic   RESET;
    logic   cmd_req;
    cmd_e   cmd;
    sq_t    peek_sq;
    logic   cmd_ack;
    piece_t peek_piece;
    sq_t    cursor;
    sq_t    selected;
    logic   piece_held;
    color_e side;

    // expected state
    piece_t      exp_board [64];
    sq_t         exp_cursor;
    color_e      exp_side;
    logic [31:0] lfsr_state;

    `include "tb_chess_checks.svh"

    chess_top i_chess_top (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .peek_sq    (peek_sq),
        .cmd_ack    (cmd_ack),
        .peek_piece (peek_piece),
        .cursor     (cursor),
        .selected   (selected),
        .piece_held (piece_held),
        .side       (side)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // reference model

    function automatic sq_t make_sq(input int row, input int col);
        sq_t s;
        s.row = 3'(row);
        s.col = 3'(col);
        return s;
    endfunction

    function automatic int sq_index(input sq_t s);
        return int'(s.row) * 8 + int'(s.col);
    endfunction

    // one step that stops at the board edge
    function automatic sq_t clamp_step(input sq_t c, input cmd_e op);
        int row;
        int col;
        row = int'(c.row);
        col = int'(c.col);
        case (op)
            CMD_LEFT:  col = col - 1;
            CMD_RIGHT: col = col + 1;
            CMD_UP:    row = row - 1;
            CMD_DOWN:  row = row + 1;
            default: ;
        endcase
        if (row < 0 || row > 7 || col < 0 || col > 7)
            return c; // off the board, step ignored
        return make_sq(row, col);
    endfunction

    function automatic logic [31:0] galois_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = galois_next(lfsr_state);
        end
    endtask

    task automatic init_model();
        kind_e back_rank [8];
        back_rank = '{ROOK, KNIGHT, BISHOP, QUEEN, KING, BISHOP, KNIGHT, ROOK};
        for (int i = 0; i < 64; i++)
            exp_board[i] = NO_PIECE;
        for (int c = 0; c < 8; c++) begin
            exp_board[c]      = '{color: BLACK, kind: back_rank[c]}; // row 0
            exp_board[8 + c]  = '{color: BLACK, kind: PAWN};
            exp_board[48 + c] = '{color: WHITE, kind: PAWN};
            exp_board[56 + c] = '{color: WHITE, kind: back_rank[c]}; // row 7
        end
        exp_cursor = make_sq(6, 4);
        exp_side   = WHITE;
    endtask

    task automatic abort_run(input string why);
        $display("%s at t=%0t", why, $time);
        $display(">>> FAIL");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // board and cursor helpers

    task automatic check_board();
        for (int i = 0; i < 64; i++) begin
            @(negedge CLK);
            peek_sq = sq_t'(6'(i));
            #1; // peek path is combinational
            check_piece($sformatf("peek_piece[row %0d col %0d]", i / 8, i % 8),
                        peek_piece, exp_board[i]);
        end
    endtask

    task automatic step_cursor(input cmd_e op);
        send_cmd(op);
        exp_cursor = clamp_step(exp_cursor, op);
        check_sq("cursor", cursor, exp_cursor);
    endtask

    task automatic goto_square(input sq_t target);
        cmd_e op;
        int   guard;
        guard = 0;
        while (exp_cursor != target && guard < 16) begin
            if (exp_cursor.col > target.col)
                op = CMD_LEFT;
            else if (exp_cursor.col < target.col)
                op = CMD_RIGHT;
            else if (exp_cursor.row > target.row)
                op = CMD_UP;
            else
                op = CMD_DOWN;
            step_cursor(op);
            guard++;
        end
        check_sq("cursor", cursor, target);
    endtask

    // select an own piece in either select state
    task automatic pick_up(input sq_t from);
        goto_square(from);
        send_cmd(CMD_SELECT);
        check_bit("piece_held", piece_held, 1'b1);
        check_sq("selected", selected, from);
    endtask

    task automatic complete_move(input sq_t from, input sq_t to);
        goto_square(to);
        send_cmd(CMD_SELECT);
        wait_idle();
        exp_board[sq_index(to)]   = exp_board[sq_index(from)];
        exp_board[sq_index(from)] = NO_PIECE;
        exp_side = (exp_side == WHITE) ? BLACK : WHITE;
        check_color("side", side, exp_side);
        check_bit("piece_held", piece_held, 1'b0);
        check_board();
    endtask

    task automatic play_move(input sq_t from, input sq_t to);
        pick_up(from);
        complete_move(from, to);
    endtask

    // select a destination that must be ignored
    task automatic reject_move(input sq_t from, input sq_t to);
        goto_square(to);
        send_cmd(CMD_SELECT);
        wait_idle();
        check_bit("piece_held", piece_held, 1'b1);
        check_sq("selected", selected, from);
        check_color("side", side, exp_side);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests

    task automatic test_after_reset();
        start_test();
        check_sq("cursor", cursor, make_sq(6, 4));
        check_color("side", side, WHITE);
        check_bit("piece_held", piece_held, 1'b0);
        check_bit("cmd_ack", cmd_ack, 1'b0);
        check_board();
        finish_test("after_reset");
    endtask

    task automatic test_cursor_walk();
        logic [7:0] pick;
        start_test();
        for (int i = 0; i < 40; i++) begin
            draw_bits(2, pick);
            step_cursor(cmd_e'({1'b0, pick[1:0]})); // one of the four steps
        end
        repeat (9) step_cursor(CMD_LEFT); // press against each edge
        repeat (9) step_cursor(CMD_UP);
        repeat (9) step_cursor(CMD_RIGHT);
        repeat (9) step_cursor(CMD_DOWN);
        finish_test("cursor_walk");
    endtask

    task automatic test_legal_moves();
        start_test();
        play_move(make_sq(6, 4), make_sq(4, 4)); // white pawn double step
        play_move(make_sq(0, 6), make_sq(2, 5)); // black knight
        finish_test("legal_moves");
    endtask

    task automatic test_selection_rules();
        start_test();
        goto_square(make_sq(5, 0)); // empty square
        send_cmd(CMD_SELECT);
        check_bit("piece_held", piece_held, 1'b0);
        goto_square(make_sq(1, 0)); // black pawn while white is to move
        send_cmd(CMD_SELECT);
        check_bit("piece_held", piece_held, 1'b0);
        pick_up(make_sq(6, 3));
        pick_up(make_sq(7, 6)); // reselect the knight
        complete_move(make_sq(7, 6), make_sq(5, 5));
        play_move(make_sq(1, 4), make_sq(3, 4)); // black pawn double step
        finish_test("selection_rules");
    endtask

    task automatic test_illegal_moves();
        start_test();
        pick_up(make_sq(7, 5));
        reject_move(make_sq(7, 5), make_sq(5, 4)); // bishop off the diagonal
        pick_up(make_sq(6, 0));
        reject_move(make_sq(6, 0), make_sq(3, 0)); // triple step
        pick_up(make_sq(4, 4));
        reject_move(make_sq(4, 4), make_sq(3, 4)); // black pawn in the way
        check_board();
        finish_test("illegal_moves");
    endtask

    task automatic test_capture();
        start_test();
        pick_up(make_sq(6, 3)); // switch from the held e-pawn to the d-pawn
        complete_move(make_sq(6, 3), make_sq(4, 3));
        play_move(make_sq(0, 1), make_sq(2, 2));
        play_move(make_sq(4, 3), make_sq(3, 4)); // takes the black pawn
        finish_test("capture");
    endtask

    initial begin
        RESET      = 1'b1;
        cmd_req    = 1'b0;
        cmd        = CMD_LEFT;
        peek_sq    = '0;
        lfsr_state = 32'h2ac0_c8d3;
        init_model();
        repeat (8) @(negedge CLK);
        RESET = 1'b0;

        test_after_reset();
        test_cursor_walk();
        test_legal_moves();
        test_selection_rules();
        test_illegal_moves();
        test_capture();

        $display("done, %0d checks, %0d errors", checks_run, errors_seen);
        if (errors_seen == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
chess_pkg.sv
button_port.sv
cursor_ctrl.sv
move_checker.sv
board_store.sv
turn_fsm.sv
chess_top.sv
tb_chess.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_chess \
    -f vlog.f -o sim_chess

./obj_dir/sim_chess > sim.log
cat sim.log

grep -q '^>>> PASS$' sim.log
